// File: hw/decodePkg.sv
// Decode stage widths, RV32 major opcodes, ALU and immediate encodings, bundle structs
package decodePkg;

    localparam int xlen    = 32;
    localparam int regIdxW = 5;

    // RV32 major opcodes kept by this decoder
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;

    // ALU operation class handed to the execute stage
    typedef enum logic [2:0] {
        aluOpMem    = 3'b000,
        aluOpBranch = 3'b001,
        aluOpReg    = 3'b010,
        aluOpJal    = 3'b011,
        aluOpLui    = 3'b100,
        aluOpAuipc  = 3'b101,
        aluOpImm    = 3'b110,
        aluOpJalr   = 3'b111
    } aluOpT;

    // ALU control codes, 5 is unassigned
    typedef enum logic [4:0] {
        aluAnd    = 5'd0,
        aluOr     = 5'd1,
        aluAdd    = 5'd2,
        aluXor    = 5'd3,
        aluSub    = 5'd4,
        aluSll    = 5'd6,
        aluSrl    = 5'd7,
        aluSra    = 5'd8,
        aluSlt    = 5'd9,
        aluSltu   = 5'd10,
        aluMul    = 5'd11,
        aluMulh   = 5'd12,
        aluMulhsu = 5'd13,
        aluMulhu  = 5'd14,
        aluDiv    = 5'd15,
        aluDivu   = 5'd16,
        aluRem    = 5'd17,
        aluRemu   = 5'd18
    } aluCtrlT;

    // Immediate layout; U and J share one value and split on opcode bit 3
    typedef enum logic [2:0] {
        immNone = 3'd0,
        immI    = 3'd1,
        immS    = 3'd2,
        immB    = 3'd3,
        immUJ   = 3'd4
    } immFmtT;

    typedef struct packed {
        logic [6:0]         opcode;
        logic [regIdxW-1:0] rd;
        logic [2:0]         func3;
        logic [regIdxW-1:0] rs1;
        logic [regIdxW-1:0] rs2;
        logic [6:0]         func7;
        logic [xlen-1:0]    raw;
    } instrFieldsT;

    typedef struct packed {
        logic       memWrite;
        logic       memRead;
        logic       regWrite;
        logic       aluSrc;
        aluOpT      aluOp;
        logic       memToReg;
        logic       pcSrc;
        logic [2:0] branchType;
    } ctrlT;

endpackage

// File: hw/decodeLatch.sv
// Stall-held decode pipeline register and instruction field split
`timescale 1ns/1ps

module decodeLatch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic [decodePkg::xlen-1:0]  nextInstruction,
    input  logic [decodePkg::xlen-1:0]  regValue1,
    input  logic [decodePkg::xlen-1:0]  regValue2,
    output decodePkg::instrFieldsT      fields,
    output logic [decodePkg::xlen-1:0]  value1,
    output logic [decodePkg::xlen-1:0]  value2
);

    logic [decodePkg::xlen-1:0] instr;

    // Word and operands load together, stall freezes all three
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            instr  <= '0;
            value1 <= '0;
            value2 <= '0;
        end
        else if (!stall)
        begin
            instr  <= nextInstruction;
            value1 <= regValue1;
            value2 <= regValue2;
        end
    end

    // Standard RV32 field positions
    always_comb
    begin
        fields.opcode = instr[6:0];
        fields.rd     = instr[11:7];
        fields.func3  = instr[14:12];
        fields.rs1    = instr[19:15];
        fields.rs2    = instr[24:20];
        fields.func7  = instr[31:25];
        fields.raw    = instr;
    end

endmodule

// File: hw/mainControl.sv
// Major opcode decoder producing the control bundle and the immediate format
`timescale 1ns/1ps

module mainControl (
    input  logic [6:0]          opcode,
    input  logic [2:0]          func3,
    output decodePkg::ctrlT     ctrl,
    output decodePkg::immFmtT   immFmt
);

    always_comb
    begin
        ctrl   = '0;
        immFmt = decodePkg::immNone;
        case (opcode)
            decodePkg::opLui:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = decodePkg::aluOpLui;
                immFmt        = decodePkg::immUJ;
            end
            decodePkg::opAuipc:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = decodePkg::aluOpAuipc;
                immFmt        = decodePkg::immUJ;
            end
            decodePkg::opJal:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.pcSrc    = 1'b1;
                ctrl.aluOp    = decodePkg::aluOpJal;
                immFmt        = decodePkg::immUJ;
            end
            decodePkg::opJalr:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.pcSrc    = 1'b1;
                ctrl.aluOp    = decodePkg::aluOpJalr;
                immFmt        = decodePkg::immI;
            end
            // Comparison kind comes straight from func3
            decodePkg::opBranch:
            begin
                ctrl.pcSrc      = 1'b1;
                ctrl.branchType = func3;
                ctrl.aluOp      = decodePkg::aluOpBranch;
                immFmt          = decodePkg::immB;
            end
            decodePkg::opLoad:
            begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluOp    = decodePkg::aluOpMem;
                immFmt        = decodePkg::immI;
            end
            decodePkg::opStore:
            begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = decodePkg::aluOpMem;
                immFmt        = decodePkg::immS;
            end
            decodePkg::opImm:
            begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = decodePkg::aluOpImm;
                immFmt        = decodePkg::immI;
            end
            decodePkg::opReg:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = decodePkg::aluOpReg;
            end
            // Anything else, atomics included, passes as a bubble
            default:
            begin
                ctrl   = '0;
                immFmt = decodePkg::immNone;
            end
        endcase
    end

endmodule

// File: hw/aluControl.sv
// ALU control code decoder from operation class, func3 and func7
`timescale 1ns/1ps

module aluControl (
    input  decodePkg::aluOpT    aluOp,
    input  logic                aluSrc,
    input  logic [2:0]          func3,
    input  logic [6:0]          func7,
    output decodePkg::aluCtrlT  aluControl
);

    decodePkg::aluCtrlT baseOp;
    decodePkg::aluCtrlT mulOp;

    // Base integer operation, same func3 map for register and immediate groups
    always_comb
    begin
        case (func3)
            3'b000: baseOp = decodePkg::aluAdd;
            3'b001: baseOp = decodePkg::aluSll;
            3'b010: baseOp = decodePkg::aluSlt;
            3'b011: baseOp = decodePkg::aluSltu;
            3'b100: baseOp = decodePkg::aluXor;
            3'b101: baseOp = decodePkg::aluSrl;
            3'b110: baseOp = decodePkg::aluOr;
            default: baseOp = decodePkg::aluAnd;
        endcase
    end

    // mul through remu are consecutive codes in func3 order
    assign mulOp = decodePkg::aluCtrlT'(5'(decodePkg::aluMul) + {2'b00, func3});

    // Undefined combinations fall back to code 0
    always_comb
    begin
        case (aluOp)
            decodePkg::aluOpBranch: aluControl = decodePkg::aluSub;
            decodePkg::aluOpImm:
            begin
                if (func3 != 3'b101)
                    aluControl = baseOp;
                else if (func7 == 7'b0000000)
                    aluControl = decodePkg::aluSrl;
                else if (func7 == 7'b0100000)
                    aluControl = decodePkg::aluSra;
                else
                    aluControl = decodePkg::aluAnd;
            end
            decodePkg::aluOpReg:
            begin
                case (func7)
                    7'b0000000: aluControl = baseOp;
                    7'b0000001: aluControl = mulOp;
                    7'b0100000:
                    begin
                        if (func3 == 3'b000)
                            aluControl = decodePkg::aluSub;
                        else if (func3 == 3'b101)
                            aluControl = decodePkg::aluSra;
                        else
                            aluControl = decodePkg::aluAnd;
                    end
                    default: aluControl = decodePkg::aluAnd;
                endcase
            end
            // Loads and stores always take an immediate offset, a bubble does not
            decodePkg::aluOpMem:
                aluControl = aluSrc ? decodePkg::aluAdd : decodePkg::aluAnd;
            default: aluControl = decodePkg::aluAdd;
        endcase
    end

endmodule

// File: hw/immGen.sv
// Immediate assembly and sign extension for the I, S, B, U and J formats
`timescale 1ns/1ps

module immGen (
    input  logic [decodePkg::xlen-1:0]  instr,
    input  decodePkg::immFmtT           immFmt,
    output logic [decodePkg::xlen-1:0]  imm
);

    logic [decodePkg::xlen-1:0] immU;
    logic [decodePkg::xlen-1:0] immJ;

    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        case (immFmt)
            decodePkg::immI:
                imm = {{20{instr[31]}}, instr[31:20]};
            decodePkg::immS:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // Branch offsets are halfword aligned
            decodePkg::immB:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            // Opcode bit 3 is set only for JAL
            decodePkg::immUJ:
                imm = instr[3] ? immJ : immU;
            default:
                imm = '0;
        endcase
    end

endmodule

// File: hw/decodeTop.sv
// Decode stage top level joining the pipeline register and the three decoders
`timescale 1ns/1ps

module decodeTop (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            stall,
    input  logic [decodePkg::xlen-1:0]      nextInstruction,
    input  logic [decodePkg::xlen-1:0]      regValue1,
    input  logic [decodePkg::xlen-1:0]      regValue2,
    output logic [decodePkg::regIdxW-1:0]   rs1,
    output logic [decodePkg::regIdxW-1:0]   rs2,
    output logic [decodePkg::regIdxW-1:0]   rd,
    output logic [decodePkg::xlen-1:0]      imm,
    output logic [decodePkg::xlen-1:0]      value1,
    output logic [decodePkg::xlen-1:0]      value2,
    output decodePkg::ctrlT                 ctrl,
    output decodePkg::aluCtrlT              aluControl
);

    decodePkg::instrFieldsT fields;
    decodePkg::immFmtT      immFmt;

    assign rs1 = fields.rs1;
    assign rs2 = fields.rs2;
    assign rd  = fields.rd;

    decodeLatch uLatch (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .nextInstruction (nextInstruction),
        .regValue1       (regValue1),
        .regValue2       (regValue2),
        .fields          (fields),
        .value1          (value1),
        .value2          (value2)
    );

    mainControl uMainControl (
        .opcode (fields.opcode),
        .func3  (fields.func3),
        .ctrl   (ctrl),
        .immFmt (immFmt)
    );

    aluControl uAluControl (
        .aluOp      (ctrl.aluOp),
        .aluSrc     (ctrl.aluSrc),
        .func3      (fields.func3),
        .func7      (fields.func7),
        .aluControl (aluControl)
    );

    immGen uImmGen (
        .instr  (fields.raw),
        .immFmt (immFmt),
        .imm    (imm)
    );

endmodule

// File: include/decodeModel.svh
// Reference decode model giving the expected control bundle, immediate and ALU code
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
    decodePkg::ctrlT ctrl;
    logic [31:0]     imm;
    logic [4:0]      aluCode;
} expectT;

function automatic expectT expectedDecode(input logic [31:0] word);
    expectT      e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  base;
    logic [4:0]  mulCode;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] immU;
    f3 = word[14:12];
    f7 = word[31:25];
    // Place each immediate at the top of the word, then shift it down arithmetically
    immI = $signed(word) >>> 20;
    immS = $signed({word[31:25], word[11:7], 20'b0}) >>> 20;
    immB = $signed({word[31], word[7], word[30:25], word[11:8], 1'b0, 19'b0}) >>> 19;
    immJ = $signed({word[31], word[19:12], word[20], word[30:21], 1'b0, 11'b0}) >>> 11;
    immU = {word[31:12], 12'b0};
    // Base operation codes by func3
    case (f3)
        3'b000: base = 5'd2;
        3'b001: base = 5'd6;
        3'b010: base = 5'd9;
        3'b011: base = 5'd10;
        3'b100: base = 5'd3;
        3'b101: base = 5'd7;
        3'b110: base = 5'd1;
        default: base = 5'd0;
    endcase
    // RV32M codes by func3
    case (f3)
        3'b000: mulCode = 5'd11;
        3'b001: mulCode = 5'd12;
        3'b010: mulCode = 5'd13;
        3'b011: mulCode = 5'd14;
        3'b100: mulCode = 5'd15;
        3'b101: mulCode = 5'd16;
        3'b110: mulCode = 5'd17;
        default: mulCode = 5'd18;
    endcase
    e = '0;
    case (word[6:0])
        decodePkg::opLui:
        begin
            e.ctrl.regWrite = 1'b1;
            e.ctrl.aluSrc   = 1'b1;
            e.ctrl.aluOp    = decodePkg::aluOpLui;
            e.imm           = immU;
            e.aluCode       = 5'd2;
        end
        decodePkg::opAuipc:
        begin
            e.ctrl.regWrite = 1'b1;
            e.ctrl.aluSrc   = 1'b1;
            e.ctrl.aluOp    = decodePkg::aluOpAuipc;
            e.imm           = immU;
            e.aluCode       = 5'd2;
        end
        decodePkg::opJal:
        begin
            e.ctrl.regWrite = 1'b1;
            e.ctrl.pcSrc    = 1'b1;
            e.ctrl.aluOp    = decodePkg::aluOpJal;
            e.imm           = immJ;
            e.aluCode       = 5'd2;
        end
        decodePkg::opJalr:
        begin
            e.ctrl.regWrite = 1'b1;
            e.ctrl.pcSrc    = 1'b1;
            e.ctrl.aluOp    = decodePkg::aluOpJalr;
            e.imm           = immI;
            e.aluCode       = 5'd2;
        end
        decodePkg::opBranch:
        begin
            e.ctrl.pcSrc      = 1'b1;
            e.ctrl.branchType = f3;
            e.ctrl.aluOp      = decodePkg::aluOpBranch;
            e.imm             = immB;
            e.aluCode         = 5'd4;
        end
        decodePkg::opLoad:
        begin
            e.ctrl.aluSrc   = 1'b1;
            e.ctrl.memToReg = 1'b1;
            e.ctrl.regWrite = 1'b1;
            e.ctrl.memRead  = 1'b1;
            e.ctrl.aluOp    = decodePkg::aluOpMem;
            e.imm           = immI;
            e.aluCode       = 5'd2;
        end
        decodePkg::opStore:
        begin
            e.ctrl.aluSrc   = 1'b1;
            e.ctrl.memWrite = 1'b1;
            e.ctrl.aluOp    = decodePkg::aluOpMem;
            e.imm           = immS;
            e.aluCode       = 5'd2;
        end
        decodePkg::opImm:
        begin
            e.ctrl.aluSrc   = 1'b1;
            e.ctrl.regWrite = 1'b1;
            e.ctrl.aluOp    = decodePkg::aluOpImm;
            e.imm           = immI;
            // Only the shift-right pair looks at func7
            if (f3 != 3'b101)
                e.aluCode = base;
            else if (f7 == 7'b0000000)
                e.aluCode = 5'd7;
            else if (f7 == 7'b0100000)
                e.aluCode = 5'd8;
        end
        decodePkg::opReg:
        begin
            e.ctrl.regWrite = 1'b1;
            e.ctrl.aluOp    = decodePkg::aluOpReg;
            if (f7 == 7'b0000000)
                e.aluCode = base;
            else if (f7 == 7'b0000001)
                e.aluCode = mulCode;
            else if (f7 == 7'b0100000 && f3 == 3'b000)
                e.aluCode = 5'd4;
            else if (f7 == 7'b0100000 && f3 == 3'b101)
                e.aluCode = 5'd8;
        end
        default:
            e = '0;
    endcase
    return e;
endfunction

`endif

// File: test/decodeTb.sv
// Decode stage testbench with clock, reset, directed and random stimulus and output compare
`timescale 1ns/1ps

module decodeTb;

    `include "decodeModel.svh"

    logic                  clk;
    logic                  rst;
    logic                  stall;
    logic [31:0]           nextInstruction;
    logic [31:0]           regValue1;
    logic [31:0]           regValue2;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [4:0]            rd;
    logic [31:0]           imm;
    logic [31:0]           value1;
    logic [31:0]           value2;
    decodePkg::ctrlT       ctrl;
    decodePkg::aluCtrlT    aluControl;

    integer      seed;
    logic        checkEnable;
    int          checkCount;
    logic [31:0] shadowWord;
    logic [31:0] shadowValue1;
    logic [31:0] shadowValue2;

    decodeTop uut (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .nextInstruction (nextInstruction),
        .regValue1       (regValue1),
        .regValue2       (regValue2),
        .rs1             (rs1),
        .rs2             (rs2),
        .rd              (rd),
        .imm             (imm),
        .value1          (value1),
        .value2          (value2),
        .ctrl            (ctrl),
        .aluControl      (aluControl)
    );

    always #2 clk = ~clk;

    // Last word and operands accepted with stall low
    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            shadowWord   <= '0;
            shadowValue1 <= '0;
            shadowValue2 <= '0;
        end
        else if (!stall)
        begin
            shadowWord   <= nextInstruction;
            shadowValue1 <= regValue1;
            shadowValue2 <= regValue2;
        end
    end

    task automatic endWithFailure;
        $display("TB FAILED");
        $fatal(1, "decode testbench stopped on the first error");
    endtask

    task automatic valueFail(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        $display("Fail %s expected %h actual %h", name, expected, actual);
        endWithFailure();
    endtask

    task automatic checkOutputs;
        expectT expected;
        expected = expectedDecode(shadowWord);
        assert (ctrl === expected.ctrl)
        else valueFail("ctrl", 32'(expected.ctrl), 32'(ctrl));
        assert (imm === expected.imm)
        else valueFail("imm", expected.imm, imm);
        assert (aluControl === expected.aluCode)
        else valueFail("aluControl", 32'(expected.aluCode), 32'(aluControl));
        assert (rs1 === shadowWord[19:15])
        else valueFail("rs1", 32'(shadowWord[19:15]), 32'(rs1));
        assert (rs2 === shadowWord[24:20])
        else valueFail("rs2", 32'(shadowWord[24:20]), 32'(rs2));
        assert (rd === shadowWord[11:7])
        else valueFail("rd", 32'(shadowWord[11:7]), 32'(rd));
        assert (value1 === shadowValue1)
        else valueFail("value1", shadowValue1, value1);
        assert (value2 === shadowValue2)
        else valueFail("value2", shadowValue2, value2);
        checkCount++;
    endtask

    // Outputs settle after the rising edge, so sample on the falling one
    always @(negedge clk)
    begin
        if (checkEnable)
            checkOutputs();
    end

    task automatic driveCycle(input logic stallValue, input logic [31:0] word);
        stall           = stallValue;
        nextInstruction = word;
        regValue1       = $random(seed);
        regValue2       = $random(seed);
        @(posedge clk);
        #1;
    endtask

    task automatic randomInstr(output logic [31:0] word);
        logic [31:0] pick;
        word = $random(seed);
        pick = $random(seed);
        case (pick[3:0])
            4'd0: word[6:0] = decodePkg::opLui;
            4'd1: word[6:0] = decodePkg::opAuipc;
            4'd2: word[6:0] = decodePkg::opJal;
            4'd3: word[6:0] = decodePkg::opJalr;
            4'd4, 4'd11: word[6:0] = decodePkg::opBranch;
            4'd5, 4'd12: word[6:0] = decodePkg::opLoad;
            4'd6, 4'd13: word[6:0] = decodePkg::opStore;
            4'd7:
            begin
                word[6:0] = decodePkg::opImm;
                if (pick[5])
                    word[31:25] = pick[4] ? 7'h20 : 7'h00;
            end
            4'd8, 4'd9:
            begin
                word[6:0] = decodePkg::opReg;
                case (pick[5:4])
                    2'd0: word[31:25] = 7'h00;
                    2'd1: word[31:25] = 7'h20;
                    2'd2: word[31:25] = 7'h01;
                    default: ;
                endcase
            end
            // Atomic group opcode, no longer decoded
            4'd10: word[6:0] = 7'b0101111;
            default: ;
        endcase
    endtask

    task automatic waitForChecks(input int target);
        int cycles;
        cycles = 0;
        while (checkCount < target)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > 20)
            begin
                $display("Timeout: the compare process stopped advancing");
                endWithFailure();
            end
        end
    endtask

    initial
    begin
        int          i;
        int          j;
        logic [6:0]  f7;
        logic [31:0] w;
        logic        stallBit;
        seed            = 32'h135a_80dd;
        clk             = 1'b0;
        rst             = 1'b1;
        stall           = 1'b0;
        nextInstruction = '0;
        regValue1       = '0;
        regValue2       = '0;
        checkEnable     = 1'b0;
        checkCount      = 0;
        repeat (2) @(posedge clk);
        checkEnable = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        assert (ctrl === '0) else valueFail("ctrl", 32'h0, 32'(ctrl));
        assert (imm === '0) else valueFail("imm", 32'h0, imm);
        assert (aluControl === decodePkg::aluCtrlT'(0))
        else valueFail("aluControl", 32'h0, 32'(aluControl));
        rst = 1'b0;

        // Upper, jump, memory and invalid words with negative immediates
        driveCycle(1'b0, {20'h80001, 5'd3, decodePkg::opLui});
        driveCycle(1'b0, {20'h12345, 5'd7, decodePkg::opAuipc});
        driveCycle(1'b0, {1'b1, 10'h3fe, 1'b1, 8'hff, 5'd1, decodePkg::opJal});
        driveCycle(1'b0, {12'hffc, 5'd2, 3'b000, 5'd1, decodePkg::opJalr});
        driveCycle(1'b0, {12'h800, 5'd5, 3'b010, 5'd6, decodePkg::opLoad});
        driveCycle(1'b0, {7'h40, 5'd7, 5'd8, 3'b010, 5'b10101, decodePkg::opStore});
        driveCycle(1'b0, {5'b00010, 2'b00, 5'd0, 5'd1, 3'b010, 5'd2, 7'b0101111});
        driveCycle(1'b0, 32'hffff_ffff);
        for (i = 0; i < 8; i++)
            driveCycle(1'b0, {7'h7f, 5'd3, 5'd4, 3'(i), 5'b11101, decodePkg::opBranch});
        for (i = 0; i < 8; i++)
            driveCycle(1'b0, {12'hf80, 5'd9, 3'(i), 5'd10, decodePkg::opImm});
        driveCycle(1'b0, {7'h00, 5'd4, 5'd9, 3'b101, 5'd10, decodePkg::opImm});
        driveCycle(1'b0, {7'h20, 5'd4, 5'd9, 3'b101, 5'd10, decodePkg::opImm});
        // Register group with base, alternate, RV32M and undefined func7
        for (j = 0; j < 4; j++)
        begin
            case (j)
                0: f7 = 7'h00;
                1: f7 = 7'h20;
                2: f7 = 7'h01;
                default: f7 = 7'h11;
            endcase
            for (i = 0; i < 8; i++)
                driveCycle(1'b0, {f7, 5'd11, 5'd12, 3'(i), 5'd13, decodePkg::opReg});
        end

        // Held contents must survive new inputs until stall drops
        driveCycle(1'b0, {20'habcde, 5'd9, decodePkg::opLui});
        for (i = 0; i < 4; i++)
        begin
            randomInstr(w);
            driveCycle(1'b1, w);
        end
        driveCycle(1'b0, {12'h7ff, 5'd5, 3'b000, 5'd6, decodePkg::opImm});

        for (i = 0; i < 500; i++)
        begin
            randomInstr(w);
            stallBit = ($random(seed) & 3) == 0;
            driveCycle(stallBit, w);
        end
        waitForChecks(checkCount + 4);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
hw/decodePkg.sv
hw/decodeLatch.sv
hw/mainControl.sv
hw/aluControl.sv
hw/immGen.sv
hw/decodeTop.sv
test/decodeTb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f flist.f --top-module decodeTb -o decodeSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/decodeSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
fi
exit $status
